// File: rtl/cpu_pkg.sv
// front end shared definitions
package cpu_pkg;

  // widths
  localparam int ADDR_W    = 32;
  localparam int INSTR_W   = 32;
  localparam int BYTE_W    = 8;
  localparam int REG_IDX_W = 5;

  // instruction queue sizing
  localparam int IQ_DEPTH  = 4;
  localparam int IQ_CNT_W  = 3;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [INSTR_W-1:0]   word_t;
  typedef logic [BYTE_W-1:0]    byte_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [IQ_CNT_W-1:0]  iq_cnt_t;

  localparam addr_t RESET_PC = '0;

  // rv32i major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // operation class handed to issue
  typedef enum logic [3:0] {
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_branch,
    op_load,
    op_store,
    op_alu_imm,
    op_alu_reg,
    op_illegal
  } op_class_e;

endpackage

// File: rtl/fetch_q_if.sv
// fetch to instruction queue link
interface fetch_q_if;
  import cpu_pkg::*;

  logic    push;
  addr_t   pc;
  word_t   instr;
  // empty slots left in the queue
  iq_cnt_t free;

  modport producer (output push, output pc, output instr, input free);

  modport buffer (input push, input pc, input instr, output free);

endinterface

// File: rtl/inst_q_if.sv
// instruction queue to decoder link
interface inst_q_if;
  import cpu_pkg::*;

  // head entry, valid while the queue is not empty
  logic  valid;
  addr_t pc;
  word_t instr;
  logic  pop;

  modport buffer (output valid, output pc, output instr, input pop);

  modport consumer (input valid, input pc, input instr, output pop);

endinterface

// File: rtl/byte_fetch.sv
// byte-serial instruction fetch
// builds little-endian words for the queue
module byte_fetch (
  input  logic           clk_in,
  input  logic           reset,
  input  logic           rdy_in,
  input  logic           redirect,
  input  cpu_pkg::addr_t redirect_pc,
  input  cpu_pkg::byte_t mem_din,
  output cpu_pkg::addr_t mem_a,
  fetch_q_if.producer    q
);
  import cpu_pkg::*;

  addr_t      word_pc;
  logic [1:0] lane;
  logic       pend;
  logic [1:0] take_lane;
  word_t      asm_word;
  addr_t      push_pc;
  logic       push_q;
  iq_cnt_t    inflight;
  logic       start;
  logic       issue;

  assign mem_a = {word_pc[ADDR_W-1:2], lane};

  // only start a word if a queue slot is still unclaimed
  assign start = (lane == 2'd0) && (q.free > inflight);
  // bytes of a started word always go out back to back
  assign issue = !redirect && (start || (lane != 2'd0));

  // the byte coming back belongs to the previous lane
  assign take_lane = lane - 2'd1;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      word_pc  <= RESET_PC;
      lane     <= 2'd0;
      pend     <= 1'b0;
      push_q   <= 1'b0;
      inflight <= '0;
    end else if (rdy_in) begin
      if (redirect) begin
        // drop partial word and any byte still on the bus
        word_pc  <= {redirect_pc[ADDR_W-1:2], 2'b00};
        lane     <= 2'd0;
        pend     <= 1'b0;
        push_q   <= 1'b0;
        inflight <= '0;
      end else begin
        pend   <= issue;
        push_q <= pend && (take_lane == 2'd3);
        if (issue) begin
          lane <= lane + 2'd1;
          if (lane == 2'd3) begin
            word_pc <= word_pc + addr_t'(4);
          end
        end
        inflight <= inflight + iq_cnt_t'(start) - iq_cnt_t'(push_q);
      end
    end
  end

  // word assembly
  always_ff @(posedge clk_in) begin
    if (rdy_in && pend) begin
      asm_word[take_lane*BYTE_W +: BYTE_W] <= mem_din;
      // word_pc already moved on when lane 3 went out
      if (take_lane == 2'd3) begin
        push_pc <= word_pc - addr_t'(4);
      end
    end
  end

  assign q.push  = push_q;
  assign q.pc    = push_pc;
  assign q.instr = asm_word;

  // each issued read steps the byte address by one, across word edges too
  assert property (@(posedge clk_in) disable iff (reset)
    rdy_in && issue |=> mem_a == $past(mem_a) + addr_t'(1));

  // the slot reserved at word start must still be there
  assert property (@(posedge clk_in) disable iff (reset)
    rdy_in && q.push |-> q.free != '0);

endmodule

// File: rtl/inst_queue.sv
// four-entry instruction queue
module inst_queue (
  input  logic      clk_in,
  input  logic      reset,
  input  logic      rdy_in,
  input  logic      redirect,
  fetch_q_if.buffer wr,
  inst_q_if.buffer  rd
);
  import cpu_pkg::*;

  addr_t pc_mem    [IQ_DEPTH];
  word_t instr_mem [IQ_DEPTH];

  logic [$clog2(IQ_DEPTH)-1:0] wr_ptr;
  logic [$clog2(IQ_DEPTH)-1:0] rd_ptr;
  iq_cnt_t                     count;
  logic                        do_push;
  logic                        do_pop;

  // nothing moves in a flush cycle
  assign do_push = rdy_in && !redirect && wr.push;
  assign do_pop  = rdy_in && !redirect && rd.pop;

  assign wr.free  = iq_cnt_t'(IQ_DEPTH) - count;
  assign rd.valid = (count != '0);
  assign rd.pc    = pc_mem[rd_ptr];
  assign rd.instr = instr_mem[rd_ptr];

  always_ff @(posedge clk_in) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (rdy_in) begin
      if (redirect) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (do_push) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
        if (do_pop) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        count <= count + iq_cnt_t'(do_push) - iq_cnt_t'(do_pop);
      end
    end
  end

  // entry storage
  always_ff @(posedge clk_in) begin
    if (do_push) begin
      pc_mem[wr_ptr]    <= wr.pc;
      instr_mem[wr_ptr] <= wr.instr;
    end
  end

  // fetch reservation keeps pushes within the depth
  assert property (@(posedge clk_in) disable iff (reset)
    count <= iq_cnt_t'(IQ_DEPTH));

  // decoder only pops a present head
  assert property (@(posedge clk_in) disable iff (reset)
    rdy_in && rd.pop |-> rd.valid);

endmodule

// File: rtl/inst_decode.sv
// rv32i field and immediate decoder
module inst_decode (
  input  logic               clk_in,
  input  logic               reset,
  input  logic               rdy_in,
  input  logic               redirect,
  input  logic               issue_stall,
  inst_q_if.consumer         rd,
  output logic               dec_valid,
  output cpu_pkg::addr_t     dec_pc,
  output cpu_pkg::op_class_e dec_op,
  output cpu_pkg::reg_idx_t  dec_rd,
  output cpu_pkg::reg_idx_t  dec_rs1,
  output cpu_pkg::reg_idx_t  dec_rs2,
  output cpu_pkg::word_t     dec_imm
);
  import cpu_pkg::*;

  word_t     ins;
  op_class_e op;
  reg_idx_t  rd_idx;
  word_t     imm;
  logic      load;

  assign ins = rd.instr;

  // take the head when the output register is free or handed over this cycle
  assign rd.pop = rd.valid && !redirect && (!dec_valid || !issue_stall);
  assign load   = rdy_in && rd.pop;

  always_comb begin
    case (ins[6:0])
      OPC_LUI:    op = op_lui;
      OPC_AUIPC:  op = op_auipc;
      OPC_JAL:    op = op_jal;
      OPC_JALR:   op = op_jalr;
      OPC_BRANCH: op = op_branch;
      OPC_LOAD:   op = op_load;
      OPC_STORE:  op = op_store;
      OPC_OP_IMM: op = op_alu_imm;
      OPC_OP:     op = op_alu_reg;
      default:    op = op_illegal;
    endcase
  end

  // immediate by format, sign from bit 31
  always_comb begin
    case (op)
      op_jalr, op_load, op_alu_imm: imm = {{20{ins[31]}}, ins[31:20]};
      op_store:  imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      op_branch: imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      op_lui, op_auipc: imm = {ins[31:12], 12'b0};
      op_jal:    imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      default:   imm = '0;
    endcase
  end

  // branches and stores write no register
  assign rd_idx = (op == op_branch || op == op_store) ? '0 : ins[11:7];

  always_ff @(posedge clk_in) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else if (rdy_in) begin
      if (redirect) begin
        dec_valid <= 1'b0;
      end else if (load) begin
        dec_valid <= 1'b1;
      end else if (!issue_stall) begin
        dec_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (load) begin
      dec_pc  <= rd.pc;
      dec_op  <= op;
      dec_rd  <= rd_idx;
      dec_rs1 <= ins[19:15];
      dec_rs2 <= ins[24:20];
      dec_imm <= imm;
    end
  end

  // a stalled result stays put until issue takes it
  assert property (@(posedge clk_in) disable iff (reset)
    dec_valid && issue_stall && !redirect |=>
      dec_valid && $stable(dec_pc) && $stable(dec_op) && $stable(dec_rd) &&
      $stable(dec_rs1) && $stable(dec_rs2) && $stable(dec_imm));

endmodule

// File: rtl/cpu_front.sv
// instruction front end top
module cpu_front (
  input  logic               clk_in,
  input  logic               reset,
  input  logic               rdy_in,
  input  cpu_pkg::byte_t     mem_din,
  input  logic               redirect,
  input  cpu_pkg::addr_t     redirect_pc,
  input  logic               issue_stall,
  output cpu_pkg::addr_t     mem_a,
  output logic               dec_valid,
  output cpu_pkg::addr_t     dec_pc,
  output cpu_pkg::op_class_e dec_op,
  output cpu_pkg::reg_idx_t  dec_rd,
  output cpu_pkg::reg_idx_t  dec_rs1,
  output cpu_pkg::reg_idx_t  dec_rs2,
  output cpu_pkg::word_t     dec_imm
);

  fetch_q_if fetch_q ();
  inst_q_if  inst_q ();

  byte_fetch u_fetch (
    .clk_in      (clk_in),
    .reset       (reset),
    .rdy_in      (rdy_in),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mem_din     (mem_din),
    .mem_a       (mem_a),
    .q           (fetch_q)
  );

  inst_queue u_queue (
    .clk_in   (clk_in),
    .reset    (reset),
    .rdy_in   (rdy_in),
    .redirect (redirect),
    .wr       (fetch_q),
    .rd       (inst_q)
  );

  inst_decode u_decode (
    .clk_in      (clk_in),
    .reset       (reset),
    .rdy_in      (rdy_in),
    .redirect    (redirect),
    .issue_stall (issue_stall),
    .rd          (inst_q),
    .dec_valid   (dec_valid),
    .dec_pc      (dec_pc),
    .dec_op      (dec_op),
    .dec_rd      (dec_rd),
    .dec_rs1     (dec_rs1),
    .dec_rs2     (dec_rs2),
    .dec_imm     (dec_imm)
  );

endmodule

// File: bench/tb_cpu_front.sv
// front end testbench
module tb_cpu_front;
  import cpu_pkg::*;

  localparam int NUM_INSTR = 200;
  localparam int LIMIT     = NUM_INSTR * 12 + 100;

  logic      clk_in;
  logic      reset;
  logic      rdy_in;
  byte_t     mem_din;
  logic      redirect;
  addr_t     redirect_pc;
  logic      issue_stall;
  addr_t     mem_a;
  logic      dec_valid;
  addr_t     dec_pc;
  op_class_e dec_op;
  reg_idx_t  dec_rd;
  reg_idx_t  dec_rs1;
  reg_idx_t  dec_rs2;
  word_t     dec_imm;

  logic        accept;
  word_t       head_word;
  logic [83:0] dec_all;
  logic [83:0] dec_all_q;
  addr_t       mem_a_q;
  addr_t       exp_pc;
  int          accepted;
  int          cycles;
  logic [31:0] rng;
  int          low_left;
  int          stall_left;
  int          next_redirect;

  cpu_front u_cpu_front (
    .clk_in      (clk_in),
    .reset       (reset),
    .rdy_in      (rdy_in),
    .mem_din     (mem_din),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .issue_stall (issue_stall),
    .mem_a       (mem_a),
    .dec_valid   (dec_valid),
    .dec_pc      (dec_pc),
    .dec_op      (dec_op),
    .dec_rd      (dec_rd),
    .dec_rs1     (dec_rs1),
    .dec_rs2     (dec_rs2),
    .dec_imm     (dec_imm)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [6:0] opc_entry(input logic [3:0] sel);
    case (sel)
      4'd0, 4'd9:  return OPC_LUI;
      4'd1, 4'd10: return OPC_AUIPC;
      4'd2, 4'd11: return OPC_JAL;
      4'd3, 4'd12: return OPC_JALR;
      4'd4, 4'd13: return OPC_BRANCH;
      4'd5, 4'd14: return OPC_LOAD;
      4'd6, 4'd15: return OPC_STORE;
      4'd7:        return OPC_OP_IMM;
      default:     return OPC_OP;
    endcase
  endfunction

  // program memory contents, one value per word index
  function automatic word_t mem_word(input addr_t addr);
    word_t v;
    v = xorshift(xorshift(32'd61115 ^ {2'b00, addr[31:2]}));
    // one word in eight keeps its random opcode
    if (v[27:25] != 3'd7) begin
      v[6:0] = opc_entry(v[31:28]);
    end
    return v;
  endfunction

  function automatic byte_t mem_byte(input addr_t addr);
    word_t w;
    w = mem_word(addr) >> {addr[1:0], 3'b000};
    return w[7:0];
  endfunction

  function automatic op_class_e ref_op(input word_t w);
    case (w[6:0])
      OPC_LUI:    return op_lui;
      OPC_AUIPC:  return op_auipc;
      OPC_JAL:    return op_jal;
      OPC_JALR:   return op_jalr;
      OPC_BRANCH: return op_branch;
      OPC_LOAD:   return op_load;
      OPC_STORE:  return op_store;
      OPC_OP_IMM: return op_alu_imm;
      OPC_OP:     return op_alu_reg;
      default:    return op_illegal;
    endcase
  endfunction

  function automatic word_t ref_imm(input word_t w);
    logic signed [31:0] s;
    case (ref_op(w))
      op_jalr, op_load, op_alu_imm: s = $signed(w[31:20]);
      op_store:         s = $signed({w[31:25], w[11:7]});
      op_branch:        s = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
      op_jal:           s = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
      op_lui, op_auipc: s = {w[31:12], 12'h000};
      default:          s = '0;
    endcase
    return s;
  endfunction

  function automatic reg_idx_t ref_rd(input word_t w);
    if (ref_op(w) == op_branch || ref_op(w) == op_store) begin
      return '0;
    end
    return w[11:7];
  endfunction

  task automatic report_value(input string name, input logic [83:0] expected,
                              input logic [83:0] actual);
    $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  always #2 clk_in = ~clk_in;

  assign accept    = rdy_in && dec_valid && !issue_stall && !redirect;
  assign head_word = mem_word(dec_pc);
  assign dec_all   = {dec_valid, dec_pc, dec_op, dec_rd, dec_rs1, dec_rs2, dec_imm};

  // byte-wide memory, one cycle read latency
  always @(posedge clk_in) begin
    if (rdy_in) begin
      mem_din <= mem_byte(mem_a);
    end
  end

  // expected pc and accepted count
  always @(posedge clk_in) begin
    cycles    <= cycles + 1;
    dec_all_q <= dec_all;
    mem_a_q   <= mem_a;
    if (reset) begin
      exp_pc   <= RESET_PC;
      accepted <= 0;
    end else if (rdy_in && redirect) begin
      exp_pc <= {redirect_pc[31:2], 2'b00};
    end else if (accept) begin
      exp_pc   <= exp_pc + 32'd4;
      accepted <= accepted + 1;
    end
  end

  // random pauses, stall bursts and redirects
  always @(posedge clk_in) begin
    rng = xorshift(rng);
    redirect <= 1'b0;
    if (!reset) begin
      if (low_left > 0) begin
        low_left = low_left - 1;
        rdy_in <= 1'b0;
      end else if (rng[4:0] == 5'd0) begin
        low_left = rng[7:5] % 6;
        rdy_in <= 1'b0;
      end else begin
        rdy_in <= 1'b1;
        if (accepted >= next_redirect) begin
          redirect      <= 1'b1;
          redirect_pc   <= {20'h0, rng[11:2], 2'b00};
          next_redirect = accepted + 36 + rng[14:12];
        end
      end
      if (stall_left > 0) begin
        stall_left = stall_left - 1;
        issue_stall <= 1'b1;
      end else if (rng[19:17] == 3'd0) begin
        stall_left = rng[22:20] % 5;
        issue_stall <= 1'b1;
      end else begin
        issue_stall <= 1'b0;
      end
    end
  end

  a_reset_valid: assert property (@(posedge clk_in) $fell(reset) |-> !dec_valid)
    else report_value("dec_valid", 84'(0), 84'($sampled(dec_valid)));
  a_reset_pc: assert property (@(posedge clk_in) $fell(reset) |-> mem_a == RESET_PC)
    else report_value("mem_a", 84'(RESET_PC), 84'($sampled(mem_a)));

  a_pc: assert property (@(posedge clk_in) disable iff (reset) accept |-> dec_pc == exp_pc)
    else report_value("dec_pc", 84'($sampled(exp_pc)), 84'($sampled(dec_pc)));
  a_op: assert property (@(posedge clk_in) disable iff (reset)
    accept |-> dec_op == ref_op(head_word))
    else report_value("dec_op", 84'(ref_op($sampled(head_word))), 84'($sampled(dec_op)));
  a_rd: assert property (@(posedge clk_in) disable iff (reset)
    accept |-> dec_rd == ref_rd(head_word))
    else report_value("dec_rd", 84'(ref_rd($sampled(head_word))), 84'($sampled(dec_rd)));
  a_rs1: assert property (@(posedge clk_in) disable iff (reset)
    accept |-> dec_rs1 == head_word[19:15])
    else report_value("dec_rs1", 84'($sampled(head_word[19:15])), 84'($sampled(dec_rs1)));
  a_rs2: assert property (@(posedge clk_in) disable iff (reset)
    accept |-> dec_rs2 == head_word[24:20])
    else report_value("dec_rs2", 84'($sampled(head_word[24:20])), 84'($sampled(dec_rs2)));
  a_imm: assert property (@(posedge clk_in) disable iff (reset)
    accept |-> dec_imm == ref_imm(head_word))
    else report_value("dec_imm", 84'(ref_imm($sampled(head_word))), 84'($sampled(dec_imm)));

  // held result while issue is stalled
  a_stall_hold: assert property (@(posedge clk_in) disable iff (reset)
    rdy_in && dec_valid && issue_stall && !redirect |=> dec_all === dec_all_q)
    else report_value("dec outputs", $sampled(dec_all_q), $sampled(dec_all));
  // frozen front end while memory is not ready
  a_pause_mem: assert property (@(posedge clk_in) disable iff (reset)
    !rdy_in |=> mem_a == mem_a_q)
    else report_value("mem_a", 84'($sampled(mem_a_q)), 84'($sampled(mem_a)));
  a_pause_dec: assert property (@(posedge clk_in) disable iff (reset)
    !rdy_in |=> dec_all === dec_all_q)
    else report_value("dec outputs", $sampled(dec_all_q), $sampled(dec_all));

  initial begin
    clk_in        = 1'b0;
    reset         = 1'b1;
    rdy_in        = 1'b1;
    mem_din       = '0;
    redirect      = 1'b0;
    redirect_pc   = '0;
    issue_stall   = 1'b0;
    rng           = 32'd61115;
    low_left      = 0;
    stall_left    = 0;
    next_redirect = 40;
    cycles        = 0;
    repeat (3) @(posedge clk_in);
    reset <= 1'b0;
    while (accepted < NUM_INSTR && cycles < LIMIT) begin
      @(posedge clk_in);
    end
    if (accepted >= NUM_INSTR) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("timeout: %0d of %0d instructions accepted after %0d cycles",
               accepted, NUM_INSTR, cycles);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

endmodule

// File: front_end.f
rtl/cpu_pkg.sv
rtl/fetch_q_if.sv
rtl/inst_q_if.sv
rtl/byte_fetch.sv
rtl/inst_queue.sv
rtl/inst_decode.sv
rtl/cpu_front.sv
bench/tb_cpu_front.sv

// File: Bender.yml
package:
  name: front_end

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/fetch_q_if.sv
      - rtl/inst_q_if.sv
      - rtl/byte_fetch.sv
      - rtl/inst_queue.sv
      - rtl/inst_decode.sv
      - rtl/cpu_front.sv
  - target: test
    files:
      - bench/tb_cpu_front.sv
